/* verilog/rv_decode_cfg.svh */
/*
 * width settings for the decode stage
 * data width, lane count, register index width
 */

`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// data and pc width
`define XLEN 32

// lanes per bundle, 1 to 4
`define DECODE_WIDTH 2

// architectural register index
`define ARF_IDX_W 5

`endif

/* verilog/rv_isa_pkg.sv */
/*
 * RV32I encoding types
 * major opcodes, immediate formats, instruction word
 */

package rv_isa_pkg;

        // raw instruction word
        typedef logic [31:0] inst_t;

        // major opcodes handled by the decoder
        typedef enum logic [6:0] {
                OPC_LOAD   = 7'b0000011,
                OPC_OP_IMM = 7'b0010011,
                OPC_AUIPC  = 7'b0010111,
                OPC_STORE  = 7'b0100011,
                OPC_OP     = 7'b0110011,
                OPC_LUI    = 7'b0110111,
                OPC_BRANCH = 7'b1100011
        } opcode_e;

        // immediate layouts
        typedef enum logic [2:0] {
                IMM_NONE  = 3'd0,
                IMM_I     = 3'd1,
                IMM_S     = 3'd2,
                IMM_B     = 3'd3,
                IMM_U     = 3'd4,
                IMM_SHAMT = 3'd5
        } imm_fmt_e;

        // funct7 values for base and alternate ops
        localparam logic [6:0] F7_BASE = 7'b0000000;
        localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* verilog/uop_pkg.sv */
/*
 * micro-op field enums and structs
 * fetch buffer entry and decoded micro-op
 */

`include "rv_decode_cfg.svh"

package uop_pkg;

        typedef enum logic [1:0] {
                IQ_NONE = 2'd0,
                IQ_INT  = 2'd1,
                IQ_MEM  = 2'd2
        } iq_code_e;

        typedef enum logic [1:0] {
                FU_NONE = 2'd0,
                FU_ALU  = 2'd1,
                FU_BR   = 2'd2,
                FU_MEM  = 2'd3
        } fu_code_e;

        typedef enum logic [3:0] {
                ALU_NONE = 4'd0,
                ALU_ADD  = 4'd1,
                ALU_SUB  = 4'd2,
                ALU_SLL  = 4'd3,
                ALU_SLT  = 4'd4,
                ALU_SLTU = 4'd5,
                ALU_XOR  = 4'd6,
                ALU_SRL  = 4'd7,
                ALU_SRA  = 4'd8,
                ALU_OR   = 4'd9,
                ALU_AND  = 4'd10
        } alu_type_e;

        typedef enum logic [2:0] {
                BR_NONE = 3'd0,
                BR_EQ   = 3'd1,
                BR_NE   = 3'd2,
                BR_LT   = 3'd3,
                BR_GE   = 3'd4,
                BR_LTU  = 3'd5,
                BR_GEU  = 3'd6
        } br_type_e;

        typedef enum logic [1:0] {
                MEM_NONE = 2'd0,
                MEM_LD   = 2'd1,
                MEM_LDU  = 2'd2,
                MEM_ST   = 2'd3
        } mem_type_e;

        // encoding matches funct3[1:0] of loads and stores
        typedef enum logic [1:0] {
                MEM_BYTE = 2'd0,
                MEM_HALF = 2'd1,
                MEM_WORD = 2'd2
        } mem_size_e;

        typedef enum logic [1:0] {
                RS_FROM_ZERO = 2'd0,
                RS_FROM_RF   = 2'd1,
                RS_FROM_PC   = 2'd2,
                RS_FROM_IMM  = 2'd3
        } rs_source_e;

        typedef struct packed {
                logic [`XLEN-1:0]  pc;
                rv_isa_pkg::inst_t inst;
        } fb_entry_t;

        typedef struct packed {
                logic                  valid;
                logic [`XLEN-1:0]      pc;
                rv_isa_pkg::inst_t     inst;
                iq_code_e              iq_code;
                fu_code_e              fu_code;
                alu_type_e             alu_type;
                br_type_e              br_type;
                mem_type_e             mem_type;
                mem_size_e             mem_size;
                logic [`XLEN-1:0]      imm;
                rs_source_e            rs1_source;
                logic [`ARF_IDX_W-1:0] rs1_arf_int_index;
                rs_source_e            rs2_source;
                logic [`ARF_IDX_W-1:0] rs2_arf_int_index;
                logic [`ARF_IDX_W-1:0] rd_arf_int_index;
                logic                  rd_valid;
        } micro_op_t;

endpackage

/* verilog/decode_ctrl_if.sv */
/*
 * decoded control fields, decoder to lane
 */

`timescale 1ns/1ps

interface decode_ctrl_if;
        import rv_isa_pkg::*;
        import uop_pkg::*;

        iq_code_e   iq_code;
        fu_code_e   fu_code;
        alu_type_e  alu_type;
        br_type_e   br_type;
        mem_type_e  mem_type;
        mem_size_e  mem_size;
        imm_fmt_e   imm_fmt;
        rs_source_e rs1_source;
        rs_source_e rs2_source;
        logic       rd_valid;
        logic       legal;

        modport decoder (
                output iq_code, fu_code, alu_type, br_type, mem_type, mem_size,
                       imm_fmt, rs1_source, rs2_source, rd_valid, legal
        );

        modport lane (
                input iq_code, fu_code, alu_type, br_type, mem_type, mem_size,
                      imm_fmt, rs1_source, rs2_source, rd_valid, legal
        );
endinterface

/* verilog/decode_ctrl.sv */
/*
 * opcode decoder
 * control fields, immediate format, legal flag
 */

`timescale 1ns/1ps

module decode_ctrl (
        input  rv_isa_pkg::inst_t inst,
        decode_ctrl_if.decoder    ctrl
);
        import rv_isa_pkg::*;
        import uop_pkg::*;

        opcode_e    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        alu_type_e  alu_op;
        br_type_e   br_op;

        // shared by OP_IMM and OP, reg_op selects the funct7 checks of OP
        function automatic alu_type_e alu_decode(input logic [2:0] f3,
                                                 input logic [6:0] f7,
                                                 input logic reg_op);
                alu_type_e op;
                logic      plain;
                op = ALU_NONE;
                plain = !reg_op || (f7 == F7_BASE);
                case (f3)
                        3'b000: begin
                                if (plain)
                                        op = ALU_ADD;
                                else if (f7 == F7_ALT)
                                        op = ALU_SUB;
                        end
                        3'b001: if (f7 == F7_BASE) op = ALU_SLL;
                        3'b010: if (plain) op = ALU_SLT;
                        3'b011: if (plain) op = ALU_SLTU;
                        3'b100: if (plain) op = ALU_XOR;
                        3'b101: begin
                                if (f7 == F7_BASE)
                                        op = ALU_SRL;
                                else if (f7 == F7_ALT)
                                        op = ALU_SRA;
                        end
                        3'b110: if (plain) op = ALU_OR;
                        default: if (plain) op = ALU_AND;
                endcase
                return op;
        endfunction

        function automatic br_type_e br_decode(input logic [2:0] f3);
                case (f3)
                        3'b000:  return BR_EQ;
                        3'b001:  return BR_NE;
                        3'b100:  return BR_LT;
                        3'b101:  return BR_GE;
                        3'b110:  return BR_LTU;
                        3'b111:  return BR_GEU;
                        default: return BR_NONE;
                endcase
        endfunction

        assign opcode = opcode_e'(inst[6:0]);
        assign funct3 = inst[14:12];
        assign funct7 = inst[31:25];
        assign alu_op = alu_decode(funct3, funct7, opcode == OPC_OP);
        assign br_op  = br_decode(funct3);

        always_comb begin
                ctrl.iq_code    = IQ_NONE;
                ctrl.fu_code    = FU_NONE;
                ctrl.alu_type   = ALU_NONE;
                ctrl.br_type    = BR_NONE;
                ctrl.mem_type   = MEM_NONE;
                ctrl.mem_size   = MEM_BYTE;
                ctrl.imm_fmt    = IMM_NONE;
                ctrl.rs1_source = RS_FROM_ZERO;
                ctrl.rs2_source = RS_FROM_ZERO;
                ctrl.rd_valid   = 1'b0;
                ctrl.legal      = 1'b0;
                case (opcode)
                        OPC_LUI, OPC_AUIPC: begin
                                ctrl.legal      = 1'b1;
                                ctrl.iq_code    = IQ_INT;
                                ctrl.fu_code    = FU_ALU;
                                ctrl.alu_type   = ALU_ADD;
                                ctrl.imm_fmt    = IMM_U;
                                ctrl.rs1_source = (opcode == OPC_AUIPC) ? RS_FROM_PC
                                                                        : RS_FROM_ZERO;
                                ctrl.rs2_source = RS_FROM_IMM;
                                ctrl.rd_valid   = 1'b1;
                        end
                        OPC_OP_IMM, OPC_OP: begin
                                if (alu_op != ALU_NONE) begin
                                        ctrl.legal      = 1'b1;
                                        ctrl.iq_code    = IQ_INT;
                                        ctrl.fu_code    = FU_ALU;
                                        ctrl.alu_type   = alu_op;
                                        ctrl.rs1_source = RS_FROM_RF;
                                        ctrl.rd_valid   = 1'b1;
                                        if (opcode == OPC_OP) begin
                                                ctrl.rs2_source = RS_FROM_RF;
                                        end else begin
                                                ctrl.rs2_source = RS_FROM_IMM;
                                                // shifts sit at funct3 001 and 101
                                                ctrl.imm_fmt = (funct3[1:0] == 2'b01) ?
                                                               IMM_SHAMT : IMM_I;
                                        end
                                end
                        end
                        OPC_BRANCH: begin
                                // branch target handled later, imm stays zero
                                if (br_op != BR_NONE) begin
                                        ctrl.legal      = 1'b1;
                                        ctrl.iq_code    = IQ_INT;
                                        ctrl.fu_code    = FU_BR;
                                        ctrl.br_type    = br_op;
                                        ctrl.rs1_source = RS_FROM_RF;
                                        ctrl.rs2_source = RS_FROM_RF;
                                end
                        end
                        OPC_LOAD: begin
                                // no LWU and no size 11 in RV32I
                                if (funct3[1:0] != 2'b11 && !(funct3[2] && funct3[1])) begin
                                        ctrl.legal      = 1'b1;
                                        ctrl.iq_code    = IQ_MEM;
                                        ctrl.fu_code    = FU_MEM;
                                        ctrl.mem_type   = funct3[2] ? MEM_LDU : MEM_LD;
                                        ctrl.mem_size   = mem_size_e'(funct3[1:0]);
                                        ctrl.imm_fmt    = IMM_I;
                                        ctrl.rs1_source = RS_FROM_RF;
                                        ctrl.rs2_source = RS_FROM_IMM;
                                        ctrl.rd_valid   = 1'b1;
                                end
                        end
                        OPC_STORE: begin
                                if (!funct3[2] && funct3[1:0] != 2'b11) begin
                                        ctrl.legal      = 1'b1;
                                        ctrl.iq_code    = IQ_MEM;
                                        ctrl.fu_code    = FU_MEM;
                                        ctrl.mem_type   = MEM_ST;
                                        ctrl.mem_size   = mem_size_e'(funct3[1:0]);
                                        ctrl.imm_fmt    = IMM_S;
                                        ctrl.rs1_source = RS_FROM_RF;
                                        ctrl.rs2_source = RS_FROM_RF;
                                end
                        end
                        default: begin
                                ctrl.legal = 1'b0;
                        end
                endcase
        end
endmodule

/* verilog/imm_gen.sv */
/*
 * immediate extraction and sign extension
 */

`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module imm_gen (
        input  rv_isa_pkg::inst_t    inst,
        input  rv_isa_pkg::imm_fmt_e imm_fmt,
        output logic [`XLEN-1:0]     imm
);
        import rv_isa_pkg::*;

        always_comb begin
                case (imm_fmt)
                        IMM_I:
                                imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
                        IMM_S:
                                imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
                        IMM_B:
                                imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7],
                                       inst[30:25], inst[11:8], 1'b0};
                        IMM_U:
                                imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
                        // shift amount is unsigned
                        IMM_SHAMT:
                                imm = {{(`XLEN-5){1'b0}}, inst[24:20]};
                        default:
                                imm = '0;
                endcase
        end
endmodule

/* verilog/decode_lane.sv */
/*
 * one decode lane
 * control fields, immediate and register indices into a micro-op
 */

`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module decode_lane (
        input  uop_pkg::fb_entry_t fb_entry,
        input  logic               valid,
        output uop_pkg::micro_op_t uop
);
        import uop_pkg::*;

        decode_ctrl_if         ctrl ();
        logic [`XLEN-1:0]      imm;
        logic [`ARF_IDX_W-1:0] rs1_idx;
        logic [`ARF_IDX_W-1:0] rs2_idx;
        logic [`ARF_IDX_W-1:0] rd_idx;

        decode_ctrl u_ctrl (
                .inst (fb_entry.inst),
                .ctrl (ctrl)
        );

        imm_gen u_imm (
                .inst    (fb_entry.inst),
                .imm_fmt (ctrl.imm_fmt),
                .imm     (imm)
        );

        // indices only where the operand really comes from the register file
        assign rs1_idx = (ctrl.rs1_source == RS_FROM_RF) ? fb_entry.inst[19:15] : '0;
        assign rs2_idx = (ctrl.rs2_source == RS_FROM_RF) ? fb_entry.inst[24:20] : '0;
        assign rd_idx  = ctrl.rd_valid ? fb_entry.inst[11:7] : '0;

        always_comb begin
                uop = '0;
                // illegal encodings leave the whole micro-op empty
                if (ctrl.legal) begin
                        uop.valid             = valid;
                        uop.pc                = fb_entry.pc;
                        uop.inst              = fb_entry.inst;
                        uop.iq_code           = ctrl.iq_code;
                        uop.fu_code           = ctrl.fu_code;
                        uop.alu_type          = ctrl.alu_type;
                        uop.br_type           = ctrl.br_type;
                        uop.mem_type          = ctrl.mem_type;
                        uop.mem_size          = ctrl.mem_size;
                        uop.imm               = imm;
                        uop.rs1_source        = ctrl.rs1_source;
                        uop.rs1_arf_int_index = rs1_idx;
                        uop.rs2_source        = ctrl.rs2_source;
                        uop.rs2_arf_int_index = rs2_idx;
                        uop.rd_arf_int_index  = rd_idx;
                        uop.rd_valid          = ctrl.rd_valid;
                end
        end
endmodule

/* verilog/uop_stage.sv */
/*
 * bundle register for decoded micro-ops
 */

`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module uop_stage (
        input  logic                                   clock,
        input  logic                                   rst,
        input  uop_pkg::micro_op_t [`DECODE_WIDTH-1:0] uops_in,
        output uop_pkg::micro_op_t [`DECODE_WIDTH-1:0] uops
);

        // whole bundle advances every cycle, no stall
        always_ff @(posedge clock) begin
                if (rst) begin
                        uops <= '0;
                end else begin
                        uops <= uops_in;
                end
        end
endmodule

/* verilog/rv_decode.sv */
/*
 * decode stage top
 * per-lane decoders and the output register
 */

`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module rv_decode (
        input  logic                                   clock,
        input  logic                                   rst,
        input  uop_pkg::fb_entry_t [`DECODE_WIDTH-1:0] insts,
        input  logic [`DECODE_WIDTH-1:0]               insts_valid,
        output uop_pkg::micro_op_t [`DECODE_WIDTH-1:0] uops
);
        import uop_pkg::*;

        micro_op_t [`DECODE_WIDTH-1:0] lane_uops;

        // lanes are independent of each other
        for (genvar i = 0; i < `DECODE_WIDTH; i++) begin : g_lane
                decode_lane u_lane (
                        .fb_entry (insts[i]),
                        .valid    (insts_valid[i]),
                        .uop      (lane_uops[i])
                );
        end

        uop_stage u_stage (
                .clock   (clock),
                .rst     (rst),
                .uops_in (lane_uops),
                .uops    (uops)
        );
endmodule

/* bench/rv_decode_tb.sv */
/*
 * testbench for the decode stage
 * reads test vectors, drives bundles, checks micro-ops one cycle later
 */

`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module rv_decode_tb;
        import uop_pkg::*;

        localparam int UOP_W = $bits(micro_op_t);

        logic                          clock;
        logic                          rst;
        fb_entry_t [`DECODE_WIDTH-1:0] insts;
        logic [`DECODE_WIDTH-1:0]      insts_valid;
        micro_op_t [`DECODE_WIDTH-1:0] uops;

        // vectors as read from the file
        string     test_name[$];
        fb_entry_t test_in[$];
        logic      test_valid[$];
        micro_op_t test_exp[$];

        // expected micro-ops of the bundle in flight
        string     pend_name[$];
        micro_op_t pend_exp[$];

        int errors = 0;
        int checks = 0;
        int cycles = 0;
        int cycle_limit = 1000;

        rv_decode dut0 (
                .clock       (clock),
                .rst         (rst),
                .insts       (insts),
                .insts_valid (insts_valid),
                .uops        (uops)
        );

        initial begin
                clock = 1'b0;
                forever #2 clock = ~clock;
        end

        always @(posedge clock) begin
                cycles = cycles + 1;
                if (cycles > cycle_limit) begin
                        $display("timeout, run did not end within %0d cycles", cycle_limit);
                        $display("%0d checks, %0d errors", checks, errors);
                        $display("*** TEST FAILED ***");
                        $finish;
                end
        end

        task automatic check_value(input string name, input logic [UOP_W-1:0] expected,
                                   input logic [UOP_W-1:0] actual);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("MISMATCH %s expected %h actual %h", name, expected, actual);
                end
        endtask

        // one vector per line and # lines skipped
        task automatic read_tests();
                int          fd;
                int          n;
                string       line;
                string       name;
                logic [31:0] pc, inst, imm;
                int          valid, legal, iq, fu, alu, br, mt, ms;
                int          s1, r1, s2, r2, rd, rdv;
                micro_op_t   exp;
                fd = $fopen("bench/rv_decode_tests.txt", "r");
                if (fd == 0) begin
                        errors++;
                        $display("cannot open the test vector file bench/rv_decode_tests.txt");
                        return;
                end
                while (!$feof(fd)) begin
                        line = "";
                        n = $fgets(line, fd);
                        if (n <= 1 || line[0] == "#")
                                continue;
                        n = $sscanf(line,
                                "%s %h %h %d %d %d %d %d %d %d %d %h %d %d %d %d %d %d",
                                name, pc, inst, valid, legal, iq, fu, alu, br, mt, ms,
                                imm, s1, r1, s2, r2, rd, rdv);
                        if (n != 18) begin
                                errors++;
                                $display("malformed test vector line: %s", line);
                                continue;
                        end
                        // illegal encodings expect an empty micro-op
                        exp = '0;
                        if (legal != 0) begin
                                exp.valid             = valid[0];
                                exp.pc                = pc;
                                exp.inst              = inst;
                                exp.iq_code           = iq_code_e'(iq[1:0]);
                                exp.fu_code           = fu_code_e'(fu[1:0]);
                                exp.alu_type          = alu_type_e'(alu[3:0]);
                                exp.br_type           = br_type_e'(br[2:0]);
                                exp.mem_type          = mem_type_e'(mt[1:0]);
                                exp.mem_size          = mem_size_e'(ms[1:0]);
                                exp.imm               = imm;
                                exp.rs1_source        = rs_source_e'(s1[1:0]);
                                exp.rs1_arf_int_index = r1[`ARF_IDX_W-1:0];
                                exp.rs2_source        = rs_source_e'(s2[1:0]);
                                exp.rs2_arf_int_index = r2[`ARF_IDX_W-1:0];
                                exp.rd_arf_int_index  = rd[`ARF_IDX_W-1:0];
                                exp.rd_valid          = rdv[0];
                        end
                        test_name.push_back(name);
                        test_in.push_back({pc, inst});
                        test_valid.push_back(valid[0]);
                        test_exp.push_back(exp);
                end
                $fclose(fd);
        endtask

        // lanes past the last vector get an empty entry with the illegal opcode 0
        task automatic drive_bundle(input int b);
                int idx;
                for (int l = 0; l < `DECODE_WIDTH; l++) begin
                        idx = b * `DECODE_WIDTH + l;
                        if (idx < test_in.size()) begin
                                insts[l]       = test_in[idx];
                                insts_valid[l] = test_valid[idx];
                                pend_name.push_back(test_name[idx]);
                                pend_exp.push_back(test_exp[idx]);
                        end else begin
                                insts[l]       = '0;
                                insts_valid[l] = 1'b0;
                                pend_name.push_back("padding");
                                pend_exp.push_back('0);
                        end
                end
        endtask

        task automatic check_bundle();
                for (int l = 0; l < `DECODE_WIDTH; l++) begin
                        check_value(pend_name.pop_front(), pend_exp.pop_front(), uops[l]);
                end
        endtask

        initial begin
                int n_bundles;
                rst = 1'b1;
                insts = '0;
                insts_valid = '0;
                read_tests();
                n_bundles = (test_in.size() + `DECODE_WIDTH - 1) / `DECODE_WIDTH;
                if (n_bundles == 0) begin
                        errors++;
                        $display("no test vectors were read");
                end
                cycle_limit = 2 * n_bundles + 20;

                // legal valid bundle on the inputs that reset must keep out of uops
                for (int l = 0; l < `DECODE_WIDTH && l < test_in.size(); l++) begin
                        insts[l]       = test_in[l];
                        insts_valid[l] = 1'b1;
                end

                // outputs stay empty while reset is held
                repeat (3) begin
                        @(posedge clock);
                        #1;
                        for (int l = 0; l < `DECODE_WIDTH; l++)
                                check_value("reset", '0, uops[l]);
                end
                rst = 1'b0;

                // new bundle every cycle while the previous one is checked
                for (int b = 0; b < n_bundles; b++) begin
                        drive_bundle(b);
                        @(posedge clock);
                        #1;
                        check_bundle();
                end
                insts = '0;
                insts_valid = '0;

                $display("%0d checks, %0d errors", checks, errors);
                if (errors == 0) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end
endmodule

/* bench/rv_decode_tests.txt */
# name pc inst valid legal iq fu alu br mem_type mem_size imm rs1_src rs1 rs2_src rs2 rd rd_valid
# pc, inst and imm in hex, the rest decimal enum codes, consecutive lines share a bundle
lui          80000000 123452b7 1 1 1 1 1  0 0 0 12345000 0 0  3 0  5  1
auipc        80000004 fffff317 1 1 1 1 1  0 0 0 fffff000 2 0  3 0  6  1
addi         80000008 fff10093 1 1 1 1 1  0 0 0 ffffffff 1 2  3 0  1  1
slti         8000000c 06422193 1 1 1 1 4  0 0 0 00000064 1 4  3 0  3  1
sltiu        80000010 7ff43393 1 1 1 1 5  0 0 0 000007ff 1 8  3 0  7  1
xori         80000014 80054493 1 1 1 1 6  0 0 0 fffff800 1 10 3 0  9  1
ori          80000018 0f066593 1 1 1 1 9  0 0 0 000000f0 1 12 3 0  11 1
andi         8000001c 55577693 1 1 1 1 10 0 0 0 00000555 1 14 3 0  13 1
slli         80000020 01f81793 1 1 1 1 3  0 0 0 0000001f 1 16 3 0  15 1
srli         80000024 00495893 1 1 1 1 7  0 0 0 00000004 1 18 3 0  17 1
srai         80000028 404a5993 1 1 1 1 8  0 0 0 00000004 1 20 3 0  19 1
add          8000002c 017b0ab3 1 1 1 1 1  0 0 0 00000000 1 22 1 23 21 1
sub          80000030 41ac8c33 1 1 1 1 2  0 0 0 00000000 1 25 1 26 24 1
sll          80000034 003110b3 1 1 1 1 3  0 0 0 00000000 1 2  1 3  1  1
slt          80000038 0062a233 1 1 1 1 4  0 0 0 00000000 1 5  1 6  4  1
sltu         8000003c 009433b3 1 1 1 1 5  0 0 0 00000000 1 8  1 9  7  1
xor          80000040 00c5c533 1 1 1 1 6  0 0 0 00000000 1 11 1 12 10 1
srl          80000044 00f756b3 1 1 1 1 7  0 0 0 00000000 1 14 1 15 13 1
sra          80000048 4128d833 1 1 1 1 8  0 0 0 00000000 1 17 1 18 16 1
or           8000004c 015a69b3 1 1 1 1 9  0 0 0 00000000 1 20 1 21 19 1
and          80000050 018bfb33 1 1 1 1 10 0 0 0 00000000 1 23 1 24 22 1
beq          80000054 00208463 1 1 1 2 0  1 0 0 00000000 1 1  1 2  0  0
bne          80000058 00419463 1 1 1 2 0  2 0 0 00000000 1 3  1 4  0  0
blt          8000005c 0062c463 1 1 1 2 0  3 0 0 00000000 1 5  1 6  0  0
bge          80000060 0083d463 1 1 1 2 0  4 0 0 00000000 1 7  1 8  0  0
bltu         80000064 00a4e463 1 1 1 2 0  5 0 0 00000000 1 9  1 10 0  0
bgeu         80000068 00c5f463 1 1 1 2 0  6 0 0 00000000 1 11 1 12 0  0
lb           8000006c ffc10083 1 1 2 3 0  0 1 0 fffffffc 1 2  3 0  1  1
lh           80000070 00821183 1 1 2 3 0  0 1 1 00000008 1 4  3 0  3  1
lw           80000074 01032283 1 1 2 3 0  0 1 2 00000010 1 6  3 0  5  1
lbu          80000078 00144383 1 1 2 3 0  0 2 0 00000001 1 8  3 0  7  1
lhu          8000007c 00255483 1 1 2 3 0  0 2 1 00000002 1 10 3 0  9  1
sb           80000080 002082a3 1 1 2 3 0  0 3 0 00000005 1 1  1 2  0  0
sh           80000084 fe419d23 1 1 2 3 0  0 3 1 fffffffa 1 3  1 4  0  0
jal          80000088 000000ef 1 0 0 0 0  0 0 0 00000000 0 0  0 0  0  0
sw           8000008c 0462a023 1 1 2 3 0  0 3 2 00000040 1 5  1 6  0  0
ecall        80000090 00000073 1 0 0 0 0  0 0 0 00000000 0 0  0 0  0  0
addi_novalid 80000094 fff10093 0 1 1 1 1  0 0 0 ffffffff 1 2  3 0  1  1
mul          80000098 023100b3 1 0 0 0 0  0 0 0 00000000 0 0  0 0  0  0

/* rv_decode.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/uop_pkg.sv
verilog/decode_ctrl_if.sv
verilog/decode_ctrl.sv
verilog/imm_gen.sv
verilog/decode_lane.sv
verilog/uop_stage.sv
verilog/rv_decode.sv
bench/rv_decode_tb.sv

/* Bender.yml */
package:
  name: rv_decode

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/uop_pkg.sv
      - verilog/decode_ctrl_if.sv
      - verilog/decode_ctrl.sv
      - verilog/imm_gen.sv
      - verilog/decode_lane.sv
      - verilog/uop_stage.sv
      - verilog/rv_decode.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/rv_decode_tb.sv
